// ==== hdl/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data path width
`define LSU_XLEN 32

// Byte address width of the local RAM space
`define LSU_ADDR_W 12

// RAM depth in words, covers the whole address space
`define LSU_RAM_WORDS 1024

// Completion tag width
`define LSU_TAG_W 4

// Issue to completion latency in cycles
`define LSU_LAT 3

`endif

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  localparam int LSU_BYTES = `LSU_XLEN / 8;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'h03;
  localparam logic [6:0] OPC_STORE = 7'h23;

  // funct3 values shared by loads and stores
  localparam logic [2:0] F3_B  = 3'd0;
  localparam logic [2:0] F3_H  = 3'd1;
  localparam logic [2:0] F3_W  = 3'd2;
  localparam logic [2:0] F3_BU = 3'd4;
  localparam logic [2:0] F3_HU = 3'd5;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } lsu_itype_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } lsu_stype_t;

  // Same word, load or store field layout
  typedef union packed {
    lsu_itype_t i;
    lsu_stype_t s;
  } lsu_inst_u;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } lsu_size_e;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } lsu_sign_e;

  typedef enum logic [1:0] {
    EXC_NONE     = 2'd0,
    EXC_MISALIGN = 2'd1,
    EXC_ACCESS   = 2'd2
  } lsu_exc_e;

  typedef struct packed {
    logic      is_load;
    lsu_size_e size;
    lsu_sign_e sign;
  } lsu_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_stage_if.sv ====
`default_nettype none

`include "lsu_params.svh"

interface lsu_stage_if
  import lsu_pkg::*;
();

  logic                   valid;
  lsu_ctrl_t              ctrl;
  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_XLEN-1:0]   st_data;
  logic [`LSU_TAG_W-1:0]  tag;
  lsu_exc_e               exc;

  // Whole pipe moves one step
  logic                   adv;

  modport src (output valid, ctrl, addr, st_data, tag, exc, input adv);

  modport dst (input valid, ctrl, addr, st_data, tag, exc, output adv);

endinterface

`default_nettype wire

// ==== hdl/lsu_window_regs.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_window_regs (
  input  wire                    i_clk,
  input  wire                    i_reset_n,

  input  wire                    i_cfg_valid,
  input  wire                    i_cfg_sel,
  input  wire [`LSU_ADDR_W-1:0]  i_cfg_data,

  output logic [`LSU_ADDR_W-1:0] o_win_base,
  output logic [`LSU_ADDR_W-1:0] o_win_limit
);

  logic w_wr_base;
  logic w_wr_limit;

  // sel 0 is the base, sel 1 the limit
  assign w_wr_base  = i_cfg_valid & ~i_cfg_sel;
  assign w_wr_limit = i_cfg_valid & i_cfg_sel;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_win_base <= '0;
    end else if (w_wr_base) begin
      o_win_base <= i_cfg_data;
    end
  end

  // Open to the top of the space out of reset
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_win_limit <= '1;
    end else if (w_wr_limit) begin
      o_win_limit <= i_cfg_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_addr_gen.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_addr_gen
  import lsu_pkg::*;
(
  input  wire                   i_clk,
  input  wire                   i_reset_n,

  input  wire                   i_issue_valid,
  output logic                  o_issue_ready,
  input  wire [31:0]            i_issue_inst,
  input  wire [`LSU_XLEN-1:0]   i_issue_base,
  input  wire [`LSU_XLEN-1:0]   i_issue_st_data,
  input  wire [`LSU_TAG_W-1:0]  i_issue_tag,

  input  wire [`LSU_ADDR_W-1:0] i_win_base,
  input  wire [`LSU_ADDR_W-1:0] i_win_limit,

  lsu_stage_if.src              stage
);

  logic                   r_ex0_valid;
  lsu_inst_u              r_ex0_inst;
  logic [`LSU_XLEN-1:0]   r_ex0_base;
  logic [`LSU_XLEN-1:0]   r_ex0_st_data;
  logic [`LSU_TAG_W-1:0]  r_ex0_tag;

  lsu_ctrl_t              w_ctrl;
  logic [11:0]            w_imm;
  logic [`LSU_ADDR_W-1:0] w_addr;
  logic                   w_misalign;
  logic                   w_access;
  lsu_exc_e               w_exc;

  assign o_issue_ready = stage.adv;

  // EX0 issue register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
    end else if (stage.adv) begin
      r_ex0_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (stage.adv) begin
      r_ex0_inst    <= i_issue_inst;
      r_ex0_base    <= i_issue_base;
      r_ex0_st_data <= i_issue_st_data;
      r_ex0_tag     <= i_issue_tag;
    end
  end

  // funct3 sits in the same place in both layouts
  always_comb begin
    w_ctrl.is_load = (r_ex0_inst.i.opcode != OPC_STORE);
    w_ctrl.size    = SIZE_W;
    w_ctrl.sign    = SIGN_S;
    case (r_ex0_inst.i.funct3)
      F3_B: w_ctrl.size = SIZE_B;
      F3_H: w_ctrl.size = SIZE_H;
      F3_W: w_ctrl.size = SIZE_W;
      F3_BU: begin
        if (w_ctrl.is_load) begin
          w_ctrl.size = SIZE_B;
          w_ctrl.sign = SIGN_U;
        end
      end
      F3_HU: begin
        if (w_ctrl.is_load) begin
          w_ctrl.size = SIZE_H;
          w_ctrl.sign = SIGN_U;
        end
      end
      default: ;
    endcase
  end

  assign w_imm = w_ctrl.is_load ? r_ex0_inst.i.imm :
                                  {r_ex0_inst.s.imm_hi, r_ex0_inst.s.imm_lo};

  assign w_addr = r_ex0_base[`LSU_ADDR_W-1:0] + `LSU_ADDR_W'($signed(w_imm));

  assign w_misalign = ((w_ctrl.size == SIZE_H) & w_addr[0]) |
                      ((w_ctrl.size == SIZE_W) & (w_addr[1:0] != 2'b00));
  assign w_access   = (w_addr < i_win_base) | (w_addr > i_win_limit);

  // Misalignment wins over the window check
  assign w_exc = w_misalign ? EXC_MISALIGN :
                 w_access   ? EXC_ACCESS   : EXC_NONE;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      stage.valid <= 1'b0;
    end else if (stage.adv) begin
      stage.valid <= r_ex0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (stage.adv) begin
      stage.ctrl    <= w_ctrl;
      stage.addr    <= w_addr;
      stage.st_data <= r_ex0_st_data;
      stage.tag     <= r_ex0_tag;
      stage.exc     <= w_exc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_mem_stage.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_mem_stage
  import lsu_pkg::*;
(
  input  wire                   i_clk,
  input  wire                   i_reset_n,

  lsu_stage_if.dst              stage,

  input  wire                   i_done_ready,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_exc_e              o_done_exc,
  output logic [`LSU_XLEN-1:0]  o_done_data
);

  localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

  logic [`LSU_XLEN-1:0]  mem [`LSU_RAM_WORDS];

  logic                  w_adv;
  logic [IDX_W-1:0]      w_idx;
  logic [LSU_BYTES-1:0]  w_be;
  logic [`LSU_XLEN-1:0]  w_wdata;
  logic                  w_wr_en;

  logic                  r_ex2_valid;
  lsu_ctrl_t             r_ex2_ctrl;
  logic [1:0]            r_ex2_off;
  logic [`LSU_TAG_W-1:0] r_ex2_tag;
  lsu_exc_e              r_ex2_exc;
  logic [`LSU_XLEN-1:0]  r_ex2_rdata;

  logic [`LSU_XLEN-1:0]  w_lane;
  logic [`LSU_XLEN-1:0]  w_ext;

  // Stall everything only while a completion waits
  assign w_adv     = ~o_done_valid | i_done_ready;
  assign stage.adv = w_adv;

  assign w_idx = stage.addr[IDX_W+1:2];

  // Replicate store data across lanes, enables pick the bytes
  always_comb begin
    case (stage.ctrl.size)
      SIZE_B: begin
        w_be    = LSU_BYTES'(1) << stage.addr[1:0];
        w_wdata = {LSU_BYTES{stage.st_data[7:0]}};
      end
      SIZE_H: begin
        w_be    = LSU_BYTES'(3) << {stage.addr[1], 1'b0};
        w_wdata = {(LSU_BYTES / 2){stage.st_data[15:0]}};
      end
      default: begin
        w_be    = '1;
        w_wdata = stage.st_data;
      end
    endcase
  end

  assign w_wr_en = w_adv & stage.valid & ~stage.ctrl.is_load & (stage.exc == EXC_NONE);

  always_ff @(posedge i_clk) begin
    if (w_wr_en) begin
      for (int b = 0; b < LSU_BYTES; b++) begin
        if (w_be[b]) begin
          mem[w_idx][b*8 +: 8] <= w_wdata[b*8 +: 8];
        end
      end
    end
  end

  // EX2 read register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_valid <= 1'b0;
    end else if (w_adv) begin
      r_ex2_valid <= stage.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_adv) begin
      r_ex2_ctrl  <= stage.ctrl;
      r_ex2_off   <= stage.addr[1:0];
      r_ex2_tag   <= stage.tag;
      r_ex2_exc   <= stage.exc;
      r_ex2_rdata <= mem[w_idx];
    end
  end

  assign w_lane = r_ex2_rdata >> {r_ex2_off, 3'b000};

  always_comb begin
    case (r_ex2_ctrl.size)
      SIZE_B: begin
        w_ext = {{(`LSU_XLEN-8){w_lane[7] & (r_ex2_ctrl.sign == SIGN_S)}}, w_lane[7:0]};
      end
      SIZE_H: begin
        w_ext = {{(`LSU_XLEN-16){w_lane[15] & (r_ex2_ctrl.sign == SIGN_S)}}, w_lane[15:0]};
      end
      default: w_ext = w_lane;
    endcase
    // Stores and faults return zero
    if (!r_ex2_ctrl.is_load || (r_ex2_exc != EXC_NONE)) begin
      w_ext = '0;
    end
  end

  // Completion register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done_valid <= 1'b0;
    end else if (w_adv) begin
      o_done_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_adv) begin
      o_done_tag  <= r_ex2_tag;
      o_done_exc  <= r_ex2_exc;
      o_done_data <= w_ext;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_pipe_top.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_pipe_top
  import lsu_pkg::*;
(
  input  wire                   i_clk,
  input  wire                   i_reset_n,

  input  wire                   i_issue_valid,
  output logic                  o_issue_ready,
  input  wire [31:0]            i_issue_inst,
  input  wire [`LSU_XLEN-1:0]   i_issue_base,
  input  wire [`LSU_XLEN-1:0]   i_issue_st_data,
  input  wire [`LSU_TAG_W-1:0]  i_issue_tag,

  input  wire                   i_cfg_valid,
  input  wire                   i_cfg_sel,
  input  wire [`LSU_ADDR_W-1:0] i_cfg_data,

  output logic                  o_done_valid,
  input  wire                   i_done_ready,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_exc_e              o_done_exc,
  output logic [`LSU_XLEN-1:0]  o_done_data
);

  logic [`LSU_ADDR_W-1:0] w_win_base;
  logic [`LSU_ADDR_W-1:0] w_win_limit;

  lsu_stage_if u_stage_if ();

  lsu_window_regs u_window_regs (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_sel   (i_cfg_sel),
    .i_cfg_data  (i_cfg_data),
    .o_win_base  (w_win_base),
    .o_win_limit (w_win_limit)
  );

  // EX0 and EX1
  lsu_addr_gen u_addr_gen (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_issue_valid   (i_issue_valid),
    .o_issue_ready   (o_issue_ready),
    .i_issue_inst    (i_issue_inst),
    .i_issue_base    (i_issue_base),
    .i_issue_st_data (i_issue_st_data),
    .i_issue_tag     (i_issue_tag),
    .i_win_base      (w_win_base),
    .i_win_limit     (w_win_limit),
    .stage           (u_stage_if.src)
  );

  // EX2 and completion
  lsu_mem_stage u_mem_stage (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .stage        (u_stage_if.dst),
    .i_done_ready (i_done_ready),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag),
    .o_done_exc   (o_done_exc),
    .o_done_data  (o_done_data)
  );

endmodule

`default_nettype wire

// ==== dv/lsu_pipe_tb.sv ====
`default_nettype none

`include "lsu_params.svh"

module lsu_pipe_tb
  import lsu_pkg::*;
();

  localparam int TIMEOUT = 1000;
  localparam logic [31:0] SEED = 32'd75206;

  logic                   i_clk = 1'b0;
  logic                   i_reset_n;
  logic                   i_issue_valid;
  logic                   o_issue_ready;
  logic [31:0]            i_issue_inst;
  logic [`LSU_XLEN-1:0]   i_issue_base;
  logic [`LSU_XLEN-1:0]   i_issue_st_data;
  logic [`LSU_TAG_W-1:0]  i_issue_tag;
  logic                   i_cfg_valid;
  logic                   i_cfg_sel;
  logic [`LSU_ADDR_W-1:0] i_cfg_data;
  logic                   o_done_valid;
  logic                   i_done_ready;
  logic [`LSU_TAG_W-1:0]  o_done_tag;
  lsu_exc_e               o_done_exc;
  logic [`LSU_XLEN-1:0]   o_done_data;

  // Byte model of the RAM and the access window
  logic [7:0]             model_mem [2**`LSU_ADDR_W];
  logic [`LSU_ADDR_W-1:0] win_base;
  logic [`LSU_ADDR_W-1:0] win_limit;

  // Completions still owed, oldest first
  logic [`LSU_TAG_W-1:0]  exp_tag [$];
  lsu_exc_e               exp_exc [$];
  logic [`LSU_XLEN-1:0]   exp_data [$];

  logic [`LSU_TAG_W-1:0]  next_tag;
  logic                   issue_taken;
  logic                   bp_en;
  logic [31:0]            stim_state;
  logic [31:0]            ready_state;
  int                     error_count;
  int                     check_count;
  string                  test_name;

  lsu_pipe_top u_lsu_pipe_top (.*);

  always #4 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, OPC_LOAD};
  endfunction

  function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {a[7:0] ^ 8'hC3, a, ~a};
  endfunction

  // Expected exception and data, updates the model for good stores
  task automatic predict(input logic [31:0] inst, input logic [31:0] base,
                         input logic [31:0] st_data, output lsu_exc_e exc,
                         output logic [31:0] data);
    logic                   is_store;
    logic [11:0]            imm;
    logic [31:0]            sum;
    logic [`LSU_ADDR_W-1:0] addr;
    int                     nbytes;
    logic                   sext;
    is_store = (inst[6:0] == OPC_STORE);
    imm      = is_store ? {inst[31:25], inst[11:7]} : inst[31:20];
    sum      = base + {{20{imm[11]}}, imm};
    addr     = sum[`LSU_ADDR_W-1:0];
    nbytes   = 4;
    sext     = 1'b0;
    case (inst[14:12])
      F3_B: begin
        nbytes = 1;
        sext   = 1'b1;
      end
      F3_H: begin
        nbytes = 2;
        sext   = 1'b1;
      end
      F3_BU: nbytes = is_store ? 4 : 1;
      F3_HU: nbytes = is_store ? 4 : 2;
      default: nbytes = 4;
    endcase
    data = '0;
    if ((nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00)) begin
      exc = EXC_MISALIGN;
    end else if (addr < win_base || addr > win_limit) begin
      exc = EXC_ACCESS;
    end else begin
      exc = EXC_NONE;
      for (int k = 0; k < nbytes; k++) begin
        if (is_store) begin
          model_mem[addr + `LSU_ADDR_W'(k)] = st_data[8*k +: 8];
        end else begin
          data[8*k +: 8] = model_mem[addr + `LSU_ADDR_W'(k)];
        end
      end
      if (sext && nbytes == 1) begin
        data = {{24{data[7]}}, data[7:0]};
      end
      if (sext && nbytes == 2) begin
        data = {{16{data[15]}}, data[15:0]};
      end
    end
  endtask

  task automatic finish_run();
    $display("Completions checked: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic check_completion();
    check_count++;
    if (exp_tag.size() == 0) begin
      $display("Completion with tag %0d in %s with none outstanding", o_done_tag, test_name);
      error_count++;
    end else begin
      if (o_done_tag !== exp_tag[0]) begin
        $display("Mismatch in %s: tag expected %0d actual %0d",
                 test_name, exp_tag[0], o_done_tag);
        error_count++;
      end
      if (o_done_exc !== exp_exc[0]) begin
        $display("Mismatch in %s (tag %0d): exception expected %0d actual %0d",
                 test_name, exp_tag[0], exp_exc[0], o_done_exc);
        error_count++;
      end
      if (o_done_data !== exp_data[0]) begin
        $display("Mismatch in %s (tag %0d): data expected %h actual %h",
                 test_name, exp_tag[0], exp_data[0], o_done_data);
        error_count++;
      end
      void'(exp_tag.pop_front());
      void'(exp_exc.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  // Falling edge to falling edge, handshakes seen at the rising edge
  task automatic tick();
    @(posedge i_clk);
    issue_taken = i_issue_valid & o_issue_ready;
    if (o_done_valid && i_done_ready) begin
      check_completion();
    end
    @(negedge i_clk);
    if (bp_en) begin
      ready_state  = xorshift32(ready_state);
      i_done_ready = ready_state[5];
    end else begin
      i_done_ready = 1'b1;
    end
  endtask

  task automatic issue(input logic [31:0] inst, input logic [31:0] base,
                       input logic [31:0] st_data);
    lsu_exc_e    exc;
    logic [31:0] data;
    int          waited;
    predict(inst, base, st_data, exc, data);
    i_issue_valid   = 1'b1;
    i_issue_inst    = inst;
    i_issue_base    = base;
    i_issue_st_data = st_data;
    i_issue_tag     = next_tag;
    waited = 0;
    tick();
    while (!issue_taken) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout waiting for issue ready in %s", test_name);
        error_count++;
        finish_run();
      end
      tick();
    end
    exp_tag.push_back(next_tag);
    exp_exc.push_back(exc);
    exp_data.push_back(data);
    next_tag = next_tag + `LSU_TAG_W'(1);
    i_issue_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_tag.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout with %0d completions outstanding in %s", exp_tag.size(), test_name);
        error_count++;
        finish_run();
      end
      tick();
    end
  endtask

  task automatic write_cfg(input logic sel, input logic [`LSU_ADDR_W-1:0] data);
    i_cfg_valid = 1'b1;
    i_cfg_sel   = sel;
    i_cfg_data  = data;
    tick();
    i_cfg_valid = 1'b0;
    if (sel) begin
      win_limit = data;
    end else begin
      win_base = data;
    end
  endtask

  task automatic init_memory();
    test_name = "init";
    for (int a = 0; a < 2**`LSU_ADDR_W; a += 4) begin
      issue(store_inst(F3_W, 12'd0), 32'(a), fill_word(`LSU_ADDR_W'(a)));
    end
    drain();
  endtask

  task automatic test_round_trip();
    logic [31:0] base;
    test_name = "round_trip";
    for (int n = 0; n < 3; n++) begin
      stim_state = xorshift32(stim_state);
      base = {stim_state[31:2], 2'b00};
      issue(store_inst(F3_W, 12'd0), base, xorshift32(stim_state));
      issue(store_inst(F3_B, 12'd1), base, 32'hDEAD_BE80);
      issue(store_inst(F3_H, 12'd2), base, 32'h1234_F00D);
      for (int off = 0; off < 4; off++) begin
        issue(load_inst(F3_B, 12'(off)), base, '0);
        issue(load_inst(F3_BU, 12'(off)), base, '0);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue(load_inst(F3_H, 12'(off)), base, '0);
        issue(load_inst(F3_HU, 12'(off)), base, '0);
      end
      issue(load_inst(F3_W, 12'd0), base, '0);
    end
    drain();
  endtask

  task automatic test_imm_forms();
    test_name = "imm_forms";
    issue(store_inst(F3_W, 12'hFF0), 32'h0000_0230, 32'hCAFE_0001);
    issue(load_inst(F3_W, 12'h020), 32'h0000_0200, '0);
    // Wraps below zero to the top word
    issue(store_inst(F3_H, 12'hFEC), 32'h0000_0010, 32'h0000_9ABC);
    issue(load_inst(F3_HU, 12'h0FC), 32'h0000_0F00, '0);
    issue(store_inst(F3_B, 12'h7FF), 32'h0000_0500, 32'h0000_00A5);
    issue(load_inst(F3_B, 12'hFFF), 32'h0000_0D00, '0);
    issue(store_inst(F3_W, 12'h800), 32'h0000_0900, 32'h0BAD_F00D);
    issue(load_inst(F3_W, 12'h008), 32'h0000_00F8, '0);
    issue(store_inst(F3_W, 12'h000), 32'hABCD_E340, 32'h7654_3210);
    issue(load_inst(F3_W, 12'h004), 32'h0000_033C, '0);
    drain();
  endtask

  task automatic test_misalign();
    test_name = "misalign";
    issue(store_inst(F3_W, 12'd0), 32'h300, 32'h1122_3344);
    issue(store_inst(F3_H, 12'd1), 32'h300, 32'hFFFF_FFFF);
    issue(store_inst(F3_W, 12'd2), 32'h300, 32'hFFFF_FFFF);
    issue(store_inst(F3_W, 12'd3), 32'h300, 32'hFFFF_FFFF);
    issue(load_inst(F3_H, 12'd1), 32'h300, '0);
    issue(load_inst(F3_HU, 12'd3), 32'h300, '0);
    for (int off = 1; off < 4; off++) begin
      issue(load_inst(F3_W, 12'(off)), 32'h300, '0);
    end
    issue(load_inst(F3_W, 12'd0), 32'h300, '0);
    drain();
  endtask

  task automatic test_window();
    test_name = "window";
    write_cfg(1'b0, 12'h400);
    write_cfg(1'b1, 12'h7FB);
    issue(load_inst(F3_W, 12'd0), 32'h400, '0);
    issue(load_inst(F3_B, 12'd0), 32'h3FF, '0);
    issue(load_inst(F3_B, 12'd0), 32'h7FB, '0);
    issue(load_inst(F3_BU, 12'd0), 32'h7FC, '0);
    issue(load_inst(F3_W, 12'd0), 32'h7F8, '0);
    // Misalignment ranks above the window
    issue(load_inst(F3_H, 12'd0), 32'h3FF, '0);
    issue(store_inst(F3_B, 12'd0), 32'h3FF, 32'h0000_0077);
    issue(store_inst(F3_W, 12'd0), 32'h7FC, 32'h5555_AAAA);
    issue(store_inst(F3_B, 12'd0), 32'h7FB, 32'h0000_0066);
    drain();
    write_cfg(1'b0, 12'h000);
    write_cfg(1'b1, 12'hFFF);
    issue(load_inst(F3_BU, 12'd0), 32'h3FF, '0);
    issue(load_inst(F3_W, 12'd0), 32'h7FC, '0);
    issue(load_inst(F3_W, 12'd0), 32'h7F8, '0);
    drain();
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] base;
    logic [11:0] imm;
    logic [2:0]  f3;
    test_name = "random";
    bp_en = 1'b1;
    for (int n = 0; n < 200; n++) begin
      stim_state = xorshift32(stim_state);
      r = stim_state;
      stim_state = xorshift32(stim_state);
      base = {stim_state[31:12], 4'h6, stim_state[7:0]};
      imm  = {{7{r[20]}}, r[20:16]};
      if (r[7:5] != 3'd0) begin
        base[1:0] = 2'b00;
        imm[1:0]  = 2'b00;
      end
      if (r[0]) begin
        f3 = (r[2:1] == 2'd3) ? F3_W : {1'b0, r[2:1]};
        issue(store_inst(f3, imm), base, xorshift32(r));
      end else begin
        case (r[3:1])
          3'd3: f3 = F3_W;
          3'd6: f3 = F3_B;
          3'd7: f3 = F3_HU;
          default: f3 = r[3:1];
        endcase
        issue(load_inst(f3, imm), base, '0);
      end
      if (r[9:8] == 2'b00) begin
        tick();
      end
    end
    drain();
    // Catch any duplicated completion
    repeat (8) tick();
    bp_en = 1'b0;
  endtask

  initial begin
    i_reset_n       = 1'b0;
    i_issue_valid   = 1'b0;
    i_issue_inst    = '0;
    i_issue_base    = '0;
    i_issue_st_data = '0;
    i_issue_tag     = '0;
    i_cfg_valid     = 1'b0;
    i_cfg_sel       = 1'b0;
    i_cfg_data      = '0;
    i_done_ready    = 1'b1;
    bp_en           = 1'b0;
    issue_taken     = 1'b0;
    next_tag        = '0;
    error_count     = 0;
    check_count     = 0;
    stim_state      = SEED;
    ready_state     = {SEED[15:0], SEED[31:16]};
    win_base        = '0;
    win_limit       = '1;
    test_name       = "reset";
    $display("Load/store pipe, latency %0d cycles", `LSU_LAT);
    repeat (10) @(negedge i_clk);
    i_reset_n = 1'b1;
    if (o_issue_ready !== 1'b1 || o_done_valid !== 1'b0) begin
      $display("Pipe is not idle after reset");
      error_count++;
    end
    init_memory();
    test_round_trip();
    test_imm_forms();
    test_misalign();
    test_window();
    test_random();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_stage_if.sv
hdl/lsu_window_regs.sv
hdl/lsu_addr_gen.sv
hdl/lsu_mem_stage.sv
hdl/lsu_pipe_top.sv
dv/lsu_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store pipe testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module lsu_pipe_tb -o lsu_pipe_sim
out=$(./obj_dir/lsu_pipe_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed"
